//--- rtl/hbm_timing_pkg.sv
package hbm_timing_pkg;

  //////////////////////////////////////////////////////////////////////
  // Core reset release
  //////////////////////////////////////////////////////////////////////

  // Release countdown width
  localparam int RELEASE_CNT_W = 4;

  // Countdown start, loaded on the first edge out of reset
  localparam logic [RELEASE_CNT_W-1:0] RELEASE_COUNT = 4'd10;

  // Register stages between the lock-qualified reset and dfi_rst_n
  localparam int STAGE_COUNT = 3;

  //////////////////////////////////////////////////////////////////////
  // PHY APB reset stretch
  //////////////////////////////////////////////////////////////////////

  // Stretch counter width
  localparam int APB_CNT_W = 8;

  // Cycles the APB reset is held after the system reset goes away.
  // The counter saturates here and the reset releases one edge later
  localparam logic [APB_CNT_W-1:0] APB_STRETCH = 8'd200;

endpackage

//--- rtl/dfi_pkg.sv
package dfi_pkg;

  //////////////////////////////////////////////////////////////////////
  // DFI control fields
  //////////////////////////////////////////////////////////////////////

  // One bit per rank
  localparam int DFI_CKE_W = 2;
  localparam int DFI_CK_W  = 2;

  // Both ranks on
  localparam logic [DFI_CKE_W-1:0] CKE_ON = 2'b11;

  // Clock runs on the low bit only
  localparam logic [DFI_CK_W-1:0] CK_ON = 2'b01;

  //////////////////////////////////////////////////////////////////////
  // Start-up wait after init complete
  //////////////////////////////////////////////////////////////////////

  localparam int CKE_WAIT_W = 4;

  // Count that turns CKE and CK on
  localparam logic [CKE_WAIT_W-1:0] CKE_WAIT_FIRE = 4'd14;

  // Counter stops here
  localparam logic [CKE_WAIT_W-1:0] CKE_WAIT_MAX = 4'd15;

endpackage

//--- rtl/hbm_reset_sequencer.sv
`timescale 1ns/1ns

module hbm_reset_sequencer
  import hbm_timing_pkg::*;
(
  input  logic AXI_ACLK_IN_0_buf,
  input  logic AXI_ARESET_N_0,
  input  logic mmcm_lock,
  output logic mmcm_rst,
  output logic dfi_rst_n,
  output logic phy_apb_rst_n
);

  logic                     rel_q;
  logic [RELEASE_CNT_W-1:0] rel_cnt;
  logic                     clk_rdy_q;
  logic                     qual_q;
  logic [STAGE_COUNT-1:0]   stage_q;
  logic [APB_CNT_W-1:0]     apb_cnt;
  logic                     apb_rst_n_q;

  //////////////////////////////////////////////////////////////////////
  // Clock-generator reset
  //////////////////////////////////////////////////////////////////////

  // Goes high on the first edge after reset and stays there
  always_ff @(posedge AXI_ACLK_IN_0_buf or negedge AXI_ARESET_N_0) begin
    if (!AXI_ARESET_N_0) begin
      rel_q <= 1'b0;
    end else begin
      rel_q <= 1'b1;
    end
  end

  // Clock generator held in reset until the first edge
  assign mmcm_rst = ~rel_q;

  //////////////////////////////////////////////////////////////////////
  // Core reset release
  //////////////////////////////////////////////////////////////////////

  // Countdown restarts while the release flag is still low
  always_ff @(posedge AXI_ACLK_IN_0_buf or negedge AXI_ARESET_N_0) begin
    if (!AXI_ARESET_N_0) begin
      rel_cnt <= RELEASE_COUNT;
    end else if (!rel_q) begin
      rel_cnt <= RELEASE_COUNT;
    end else if (rel_cnt != '0) begin
      rel_cnt <= rel_cnt - RELEASE_CNT_W'(1);
    end
  end

  // Clock considered ready once the countdown has run out
  always_ff @(posedge AXI_ACLK_IN_0_buf or negedge AXI_ARESET_N_0) begin
    if (!AXI_ARESET_N_0) begin
      clk_rdy_q <= 1'b0;
    end else begin
      clk_rdy_q <= (rel_cnt == '0);
    end
  end

  // Lock is sampled every cycle, a drop pulls the core back into reset
  always_ff @(posedge AXI_ACLK_IN_0_buf or negedge AXI_ARESET_N_0) begin
    if (!AXI_ARESET_N_0) begin
      qual_q <= 1'b0;
    end else begin
      qual_q <= clk_rdy_q & mmcm_lock;
    end
  end

  // Staging pipeline, last stage is the core reset
  always_ff @(posedge AXI_ACLK_IN_0_buf or negedge AXI_ARESET_N_0) begin
    if (!AXI_ARESET_N_0) begin
      stage_q <= '0;
    end else begin
      stage_q <= {stage_q[STAGE_COUNT-2:0], qual_q};
    end
  end

  assign dfi_rst_n = stage_q[STAGE_COUNT-1];

  //////////////////////////////////////////////////////////////////////
  // PHY APB reset stretch
  //////////////////////////////////////////////////////////////////////

  // Saturating count, independent of lock
  always_ff @(posedge AXI_ACLK_IN_0_buf or negedge AXI_ARESET_N_0) begin
    if (!AXI_ARESET_N_0) begin
      apb_cnt     <= '0;
      apb_rst_n_q <= 1'b0;
    end else if (apb_cnt >= APB_STRETCH) begin
      apb_rst_n_q <= 1'b1;
    end else begin
      apb_cnt     <= apb_cnt + APB_CNT_W'(1);
      apb_rst_n_q <= 1'b0;
    end
  end

  assign phy_apb_rst_n = apb_rst_n_q;

endmodule

//--- rtl/dfi_bringup.sv
`timescale 1ns/1ns

module dfi_bringup
  import dfi_pkg::*;
(
  input  logic                 AXI_ACLK_IN_0_buf,
  input  logic                 AXI_ARESET_N_0,
  input  logic                 dfi_rst_n,
  input  logic                 dfi_out_rst_n,
  input  logic                 dfi_init_complete,
  output logic                 dfi_init_start,
  output logic [DFI_CKE_W-1:0] dfi_cke,
  output logic [DFI_CK_W-1:0]  dfi_ck
);

  logic [CKE_WAIT_W-1:0] wait_cnt;

  //////////////////////////////////////////////////////////////////////
  // Init start
  //////////////////////////////////////////////////////////////////////

  // Raised once the PHY is out of its own reset, then held
  always_ff @(posedge AXI_ACLK_IN_0_buf or negedge AXI_ARESET_N_0) begin
    if (!AXI_ARESET_N_0) begin
      dfi_init_start <= 1'b0;
    end else if (!dfi_rst_n) begin
      dfi_init_start <= 1'b0;
    end else if (dfi_out_rst_n) begin
      dfi_init_start <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // CKE and CK enable
  //////////////////////////////////////////////////////////////////////

  // Counts only cycles with init complete high, so a short pulse
  // just pauses the wait
  always_ff @(posedge AXI_ACLK_IN_0_buf or negedge AXI_ARESET_N_0) begin
    if (!AXI_ARESET_N_0) begin
      wait_cnt <= '0;
    end else if (!dfi_rst_n) begin
      wait_cnt <= '0;
    end else if (dfi_init_complete && (wait_cnt != CKE_WAIT_MAX)) begin
      wait_cnt <= wait_cnt + CKE_WAIT_W'(1);
    end
  end

  // Turned on one edge after the fire count, then held
  always_ff @(posedge AXI_ACLK_IN_0_buf or negedge AXI_ARESET_N_0) begin
    if (!AXI_ARESET_N_0) begin
      dfi_cke <= '0;
      dfi_ck  <= '0;
    end else if (!dfi_rst_n) begin
      dfi_cke <= '0;
      dfi_ck  <= '0;
    end else if (wait_cnt == CKE_WAIT_FIRE) begin
      dfi_cke <= CKE_ON;
      dfi_ck  <= CK_ON;
    end
  end

endmodule

//--- rtl/hbm_bringup_top.sv
`timescale 1ns/1ns

module hbm_bringup_top
  import dfi_pkg::*;
(
  input  logic                 AXI_ACLK_IN_0_buf,
  input  logic                 AXI_ARESET_N_0,

  // Clock generator
  input  logic                 mmcm_lock,
  output logic                 mmcm_rst,

  // PHY resets
  output logic                 phy_apb_rst_n,
  output logic                 dfi_rst_n,

  // DFI start-up
  input  logic                 dfi_out_rst_n,
  input  logic                 dfi_init_complete,
  output logic                 dfi_init_start,
  output logic [DFI_CKE_W-1:0] dfi_cke,
  output logic [DFI_CK_W-1:0]  dfi_ck
);

  // Reset sequencing for the clock generator, the core and the APB side
  hbm_reset_sequencer i_reset_seq (
    .AXI_ACLK_IN_0_buf (AXI_ACLK_IN_0_buf),
    .AXI_ARESET_N_0    (AXI_ARESET_N_0),
    .mmcm_lock         (mmcm_lock),
    .mmcm_rst          (mmcm_rst),
    .dfi_rst_n         (dfi_rst_n),
    .phy_apb_rst_n     (phy_apb_rst_n)
  );

  // Core reset also clears the DFI start-up state
  dfi_bringup i_dfi_bringup (
    .AXI_ACLK_IN_0_buf (AXI_ACLK_IN_0_buf),
    .AXI_ARESET_N_0    (AXI_ARESET_N_0),
    .dfi_rst_n         (dfi_rst_n),
    .dfi_out_rst_n     (dfi_out_rst_n),
    .dfi_init_complete (dfi_init_complete),
    .dfi_init_start    (dfi_init_start),
    .dfi_cke           (dfi_cke),
    .dfi_ck            (dfi_ck)
  );

endmodule

//--- sim/tb_hbm_bringup.sv
`timescale 1ns/1ns

module tb_hbm_bringup
  import hbm_timing_pkg::*;
  import dfi_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;
  localparam int RESET_CYCLES = 4;
  localparam int MAX_CYCLES   = 1200;

  // Clock-ready is high after this edge, so the first qualified sample is one edge later
  localparam int READY_EDGE = int'(RELEASE_COUNT) + 2;

  logic                 AXI_ACLK_IN_0_buf;
  logic                 AXI_ARESET_N_0;
  logic                 mmcm_lock;
  logic                 mmcm_rst;
  logic                 phy_apb_rst_n;
  logic                 dfi_rst_n;
  logic                 dfi_out_rst_n;
  logic                 dfi_init_complete;
  logic                 dfi_init_start;
  logic [DFI_CKE_W-1:0] dfi_cke;
  logic [DFI_CK_W-1:0]  dfi_ck;

  integer seed;
  int     errors      = 0;
  int     checks      = 0;
  int     cycle_count = 0;
  int     lock_edge;
  int     drop_edge;

  // Reference model state
  int   edge_num       = 0;
  int   high_count     = 0;
  logic exp_mmcm_rst   = 1'b1;
  logic exp_apb_rst_n  = 1'b0;
  logic exp_dfi_rst_n  = 1'b0;
  logic exp_init       = 1'b0;
  logic exp_cke_on     = 1'b0;
  logic prev_dfi_rst_n = 1'b0;
  logic lock_seen [0:MAX_CYCLES+15];

  hbm_bringup_top i_dut (
    .AXI_ACLK_IN_0_buf (AXI_ACLK_IN_0_buf),
    .AXI_ARESET_N_0    (AXI_ARESET_N_0),
    .mmcm_lock         (mmcm_lock),
    .mmcm_rst          (mmcm_rst),
    .phy_apb_rst_n     (phy_apb_rst_n),
    .dfi_rst_n         (dfi_rst_n),
    .dfi_out_rst_n     (dfi_out_rst_n),
    .dfi_init_complete (dfi_init_complete),
    .dfi_init_start    (dfi_init_start),
    .dfi_cke           (dfi_cke),
    .dfi_ck            (dfi_ck)
  );

  initial AXI_ACLK_IN_0_buf = 1'b0;
  always #(CLK_PERIOD / 2) AXI_ACLK_IN_0_buf = ~AXI_ACLK_IN_0_buf;

  //////////////////////////////////////////////////////////////////////
  // Reference model updated on each edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge AXI_ACLK_IN_0_buf or negedge AXI_ARESET_N_0) begin
    if (!AXI_ARESET_N_0) begin
      edge_num      = 0;
      high_count    = 0;
      exp_mmcm_rst  = 1'b1;
      exp_apb_rst_n = 1'b0;
      exp_dfi_rst_n = 1'b0;
      exp_init      = 1'b0;
      exp_cke_on    = 1'b0;
    end else begin
      prev_dfi_rst_n      = exp_dfi_rst_n;
      edge_num            = edge_num + 1;
      lock_seen[edge_num] = mmcm_lock;
      exp_mmcm_rst        = 1'b0;
      exp_apb_rst_n       = (edge_num > APB_STRETCH);
      // Core reset follows the qualified lock sample STAGE_COUNT edges back
      if (edge_num > READY_EDGE + STAGE_COUNT) begin
        exp_dfi_rst_n = lock_seen[edge_num - STAGE_COUNT];
      end else begin
        exp_dfi_rst_n = 1'b0;
      end
      // DFI side sees the core reset as it was before this edge
      if (!prev_dfi_rst_n) begin
        exp_init   = 1'b0;
        exp_cke_on = 1'b0;
        high_count = 0;
      end else begin
        if (high_count >= CKE_WAIT_FIRE) begin
          exp_cke_on = 1'b1;
        end
        if (dfi_out_rst_n) begin
          exp_init = 1'b1;
        end
        if (dfi_init_complete) begin
          high_count = high_count + 1;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [3:0] got,
                             input logic [3:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("FAIL %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_edge(input string what, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("FAIL %0t: %s at edge %0d, expected edge %0d", $time, what, got, exp);
    end
  endtask

  // Outputs are stable mid-cycle
  always @(negedge AXI_ACLK_IN_0_buf) begin
    check_value("mmcm_rst", 4'(mmcm_rst), 4'(exp_mmcm_rst));
    check_value("phy_apb_rst_n", 4'(phy_apb_rst_n), 4'(exp_apb_rst_n));
    check_value("dfi_rst_n", 4'(dfi_rst_n), 4'(exp_dfi_rst_n));
    check_value("dfi_init_start", 4'(dfi_init_start), 4'(exp_init));
    check_value("dfi_cke", 4'(dfi_cke), exp_cke_on ? 4'(CKE_ON) : 4'd0);
    check_value("dfi_ck", 4'(dfi_ck), exp_cke_on ? 4'(CK_ON) : 4'd0);
  end

  cke_ck_in_step: assert property (@(negedge AXI_ACLK_IN_0_buf)
    (dfi_cke == CKE_ON) == (dfi_ck == CK_ON))
    else begin
      errors++;
      $display("FAIL %0t: dfi_cke and dfi_ck disagree", $time);
    end

  core_after_clkgen: assert property (@(negedge AXI_ACLK_IN_0_buf)
    dfi_rst_n |-> !mmcm_rst)
    else begin
      errors++;
      $display("FAIL %0t: dfi_rst_n high while mmcm_rst is high", $time);
    end

  // Run limit
  always @(posedge AXI_ACLK_IN_0_buf) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the test sequence did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic step(input int n);
    repeat (n) @(posedge AXI_ACLK_IN_0_buf);
    #(DRIVE_DELAY);
  endtask

  function automatic int random_delay();
    return 4 + ($random(seed) & 15);
  endfunction

  task automatic apply_reset();
    AXI_ARESET_N_0 = 1'b0;
    repeat (RESET_CYCLES) @(posedge AXI_ACLK_IN_0_buf);
    #(DRIVE_DELAY);
    AXI_ARESET_N_0 = 1'b1;
  endtask

  // PHY leaves its reset, glitches it once, then reports init complete
  // with a short first pulse
  task automatic phy_startup();
    step(random_delay());
    dfi_out_rst_n = 1'b1;
    while (!dfi_init_start) step(1);
    dfi_out_rst_n = 1'b0;
    step(3);
    dfi_out_rst_n = 1'b1;
    step(random_delay());
    dfi_init_complete = 1'b1;
    step(6);
    dfi_init_complete = 1'b0;
    step(5);
    dfi_init_complete = 1'b1;
    while (dfi_cke == '0) step(1);
  endtask

  initial begin
    seed              = 9;
    AXI_ARESET_N_0    = 1'b0;
    mmcm_lock         = 1'b1;
    dfi_out_rst_n     = 1'b0;
    dfi_init_complete = 1'b0;

    // Lock held high from reset
    apply_reset();
    while (!dfi_rst_n) step(1);
    check_edge("dfi_rst_n rise with lock held", edge_num, READY_EDGE + 1 + STAGE_COUNT);
    phy_startup();
    while (edge_num < APB_STRETCH + 10) step(1);

    // Late lock, then a short lock drop
    mmcm_lock         = 1'b0;
    dfi_out_rst_n     = 1'b0;
    dfi_init_complete = 1'b0;
    apply_reset();
    step(20 + random_delay());
    lock_edge = edge_num;
    mmcm_lock = 1'b1;
    while (!dfi_rst_n) step(1);
    check_edge("dfi_rst_n rise after late lock", edge_num, lock_edge + 1 + STAGE_COUNT);
    phy_startup();
    step(10);
    drop_edge = edge_num + 1;
    mmcm_lock = 1'b0;
    step(2);
    mmcm_lock = 1'b1;
    while (dfi_rst_n) step(1);
    check_edge("dfi_rst_n fall after lock drop", edge_num, drop_edge + STAGE_COUNT);
    while (!dfi_rst_n) step(1);
    while (dfi_cke == '0) step(1);

    // Lock lost across the APB release edge
    while (edge_num < APB_STRETCH - 2) step(1);
    mmcm_lock = 1'b0;
    step(6);
    mmcm_lock = 1'b1;
    while (edge_num < 300) step(1);

    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- hbm_bringup.f
rtl/hbm_timing_pkg.sv
rtl/dfi_pkg.sv
rtl/hbm_reset_sequencer.sv
rtl/dfi_bringup.sv
rtl/hbm_bringup_top.sv
sim/tb_hbm_bringup.sv

//--- Makefile
# Verilator build for the HBM bring-up controller

VERILATOR   ?= verilator
FILELIST    ?= hbm_bringup.f
TOP         ?= tb_hbm_bringup
RTL_TOP     ?= hbm_bringup_top
BUILD_DIR   ?= obj_dir
JOBS        ?= 0
LINT_FLAGS  ?= -Wall
BUILD_FLAGS ?= --assert
PASS_TEXT   ?= Simulation passed

RTL_SRCS := rtl/hbm_timing_pkg.sv \
            rtl/dfi_pkg.sv \
            rtl/hbm_reset_sequencer.sv \
            rtl/dfi_bringup.sv \
            rtl/hbm_bringup_top.sv

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

# Strict lint on the design, plain lint on the whole testbench build
lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(RTL_SRCS) sim/tb_hbm_bringup.sv
	$(VERILATOR) --binary --timing $(BUILD_FLAGS) -j $(JOBS) \
	  --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
